// File: hw/leaf_pkg.sv
package leaf_pkg;

    // widths of a network packet and its fields
    localparam int packet_bits  = 49;
    localparam int payload_bits = 32;
    localparam int leaf_bits    = 5;
    localparam int port_bits    = 4;
    localparam int addr_bits    = 7;

    // packet as it travels on the tree, msb first
    typedef struct packed {
        logic                    vld;      // bit 48
        logic [leaf_bits-1:0]    leaf;     // bits 47:43, destination leaf
        logic [port_bits-1:0]    port;     // bits 42:39, destination port
        logic [addr_bits-1:0]    seq;      // bits 38:32, per port sequence
        logic [payload_bits-1:0] payload;  // bits 31:0
    } packet_t;

endpackage

// File: hw/leaf_depacketizer.sv
`timescale 1ns/1ps

module leaf_depacketizer #(
    parameter int LEAF_ID    = 3,
    parameter int NUM_PORTS  = 4,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                              clk_400,
    input  logic                              reset,
    input  logic [leaf_pkg::packet_bits-1:0]  din_leaf_bft2interface,
    input  logic [NUM_PORTS-1:0]              full,
    output logic [NUM_PORTS-1:0]              wr_en,
    output logic [leaf_pkg::payload_bits-1:0] wr_data
);

    import leaf_pkg::*;

    packet_t                 pkt;
    logic                    for_us;
    logic [NUM_PORTS-1:0]    hit;
    logic [NUM_PORTS-1:0]    hit_q;
    logic [payload_bits-1:0] data_q;

    // port fifos wrap their pointers naturally and ports are addressed by the port field
    if (FIFO_DEPTH < 2 || (FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0) begin : g_depth_check
        $error("FIFO_DEPTH must be a power of two, at least 2");
    end
    if (NUM_PORTS < 1 || NUM_PORTS > 2 ** port_bits) begin : g_ports_check
        $error("NUM_PORTS does not fit the port field");
    end

    assign pkt    = packet_t'(din_leaf_bft2interface);
    assign for_us = pkt.vld && (pkt.leaf == leaf_bits'(LEAF_ID));

    // one-hot port select, ports above NUM_PORTS match nothing
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            hit[p] = for_us && (pkt.port == port_bits'(p));
        end
    end

    always_ff @(posedge clk_400) begin
        if (reset) begin
            hit_q <= '0;
        end else begin
            hit_q <= hit;
        end
    end

    always_ff @(posedge clk_400) begin
        if (|hit) begin
            data_q <= pkt.payload;
        end
    end

    assign wr_en   = hit_q & ~full;   // dropped when the port fifo is full
    assign wr_data = data_q;          // shared by all input fifos

endmodule

// File: hw/leaf_port_fifo.sv
`timescale 1ns/1ps

module leaf_port_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                              clk_400,
    input  logic                              reset,
    input  logic                              wr_en,
    input  logic [leaf_pkg::payload_bits-1:0] wr_data,
    output logic                              full,
    output logic                              vld,
    output logic [leaf_pkg::payload_bits-1:0] data,
    input  logic                              ack
);

    import leaf_pkg::*;

    localparam int ptr_bits = $clog2(FIFO_DEPTH);
    localparam int cnt_bits = ptr_bits + 1;

    logic [payload_bits-1:0] mem [FIFO_DEPTH];
    logic [ptr_bits-1:0]     wr_ptr;
    logic [ptr_bits-1:0]     rd_ptr;
    logic [cnt_bits-1:0]     count;
    logic                    do_wr;
    logic                    do_rd;

    assign do_wr = wr_en && !full;    // write while full is lost
    assign do_rd = ack && vld;

    always_ff @(posedge clk_400) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_400) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // head entry falls through
    assign data = mem[rd_ptr];
    assign vld  = (count != '0);
    assign full = (count == cnt_bits'(FIFO_DEPTH));

endmodule

// File: hw/leaf_packetizer.sv
`timescale 1ns/1ps

module leaf_packetizer #(
    parameter int DEST_LEAF = 9,
    parameter int NUM_PORTS = 4
) (
    input  logic                                        clk_400,
    input  logic                                        reset,
    input  logic                                        resend,
    input  logic [NUM_PORTS-1:0]                        vld,
    input  logic [NUM_PORTS*leaf_pkg::payload_bits-1:0] data,
    output logic [NUM_PORTS-1:0]                        ack,
    output logic [leaf_pkg::packet_bits-1:0]            dout_leaf_interface2bft
);

    import leaf_pkg::*;

    localparam int sel_bits = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    logic [sel_bits-1:0]  last_q;
    logic [sel_bits-1:0]  grant_idx;
    logic                 any_vld;
    logic                 take;
    logic [addr_bits-1:0] seq_q [NUM_PORTS];
    packet_t              pkt_q;

    // search starts one past the last winner
    always_comb begin
        int idx;
        any_vld   = 1'b0;
        grant_idx = last_q;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            idx = (int'(last_q) + i) % NUM_PORTS;
            if (!any_vld && vld[idx]) begin
                any_vld   = 1'b1;
                grant_idx = sel_bits'(idx);
            end
        end
    end

    assign take = any_vld && !resend;   // nothing leaves a fifo during resend

    always_comb begin
        ack = '0;
        if (take) begin
            ack[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk_400) begin
        if (reset) begin
            last_q <= sel_bits'(NUM_PORTS - 1);   // port 0 first
            for (int p = 0; p < NUM_PORTS; p++) begin
                seq_q[p] <= '0;
            end
        end else if (take) begin
            last_q           <= grant_idx;
            seq_q[grant_idx] <= seq_q[grant_idx] + 1'b1;   // wraps at 128
        end
    end

    always_ff @(posedge clk_400) begin
        if (take) begin
            pkt_q.leaf    <= leaf_bits'(DEST_LEAF);
            pkt_q.port    <= port_bits'(grant_idx);
            pkt_q.seq     <= seq_q[grant_idx];
            pkt_q.payload <= data[grant_idx*payload_bits +: payload_bits];
        end
        if (reset) begin
            pkt_q.vld <= 1'b0;
        end else if (!resend) begin
            pkt_q.vld <= any_vld;   // idle cycle sends an invalid packet
        end
    end

    // register holds during resend, the network sees zeros
    assign dout_leaf_interface2bft = resend ? '0 : pkt_q;

endmodule

// File: hw/leaf_interface.sv
`timescale 1ns/1ps

module leaf_interface #(
    parameter int LEAF_ID    = 3,
    parameter int DEST_LEAF  = 9,
    parameter int NUM_PORTS  = 4,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                                        clk_400,
    input  logic                                        reset,
    input  logic [leaf_pkg::packet_bits-1:0]            din_leaf_bft2interface,
    output logic [leaf_pkg::packet_bits-1:0]            dout_leaf_interface2bft,
    input  logic                                        resend,
    input  logic                                        ap_start,
    output logic                                        reset_ap_start_user,
    output logic [NUM_PORTS*leaf_pkg::payload_bits-1:0] dout_leaf_interface2user,
    output logic [NUM_PORTS-1:0]                        vld_interface2user,
    input  logic [NUM_PORTS-1:0]                        ack_user2interface,
    input  logic [NUM_PORTS*leaf_pkg::payload_bits-1:0] din_leaf_user2interface,
    input  logic [NUM_PORTS-1:0]                        vld_user2interface,
    output logic [NUM_PORTS-1:0]                        ack_interface2user
);

    import leaf_pkg::*;

    logic [NUM_PORTS-1:0]              in_wr_en;
    logic [NUM_PORTS-1:0]              in_full;
    logic [payload_bits-1:0]           in_wr_data;
    logic [NUM_PORTS-1:0]              out_full;
    logic [NUM_PORTS-1:0]              out_vld;
    logic [NUM_PORTS-1:0]              out_ack;
    logic [NUM_PORTS*payload_bits-1:0] out_data;
    logic                              start_wait_q;

    // kernel held in reset until ap_start has been seen once
    always_ff @(posedge clk_400) begin
        if (reset) begin
            start_wait_q <= 1'b1;
        end else if (ap_start) begin
            start_wait_q <= 1'b0;
        end
    end

    assign reset_ap_start_user = start_wait_q;

    leaf_depacketizer #(
        .LEAF_ID    (LEAF_ID),
        .NUM_PORTS  (NUM_PORTS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) leaf_depacketizer_inst (
        .clk_400                (clk_400),
        .reset                  (reset),
        .din_leaf_bft2interface (din_leaf_bft2interface),
        .full                   (in_full),
        .wr_en                  (in_wr_en),
        .wr_data                (in_wr_data)
    );

    // network to kernel
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_in_fifo
        leaf_port_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) leaf_port_fifo_inst (
            .clk_400 (clk_400),
            .reset   (reset),
            .wr_en   (in_wr_en[p]),
            .wr_data (in_wr_data),
            .full    (in_full[p]),
            .vld     (vld_interface2user[p]),
            .data    (dout_leaf_interface2user[p*payload_bits +: payload_bits]),
            .ack     (ack_user2interface[p])
        );
    end

    // kernel to network
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_out_fifo
        leaf_port_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) leaf_port_fifo_inst (
            .clk_400 (clk_400),
            .reset   (reset),
            .wr_en   (vld_user2interface[p]),
            .wr_data (din_leaf_user2interface[p*payload_bits +: payload_bits]),
            .full    (out_full[p]),
            .vld     (out_vld[p]),
            .data    (out_data[p*payload_bits +: payload_bits]),
            .ack     (out_ack[p])
        );
    end

    assign ack_interface2user = ~out_full;

    leaf_packetizer #(
        .DEST_LEAF (DEST_LEAF),
        .NUM_PORTS (NUM_PORTS)
    ) leaf_packetizer_inst (
        .clk_400                 (clk_400),
        .reset                   (reset),
        .resend                  (resend),
        .vld                     (out_vld),
        .data                    (out_data),
        .ack                     (out_ack),
        .dout_leaf_interface2bft (dout_leaf_interface2bft)
    );

endmodule

// File: hw/leaf_user_kernel.sv
`timescale 1ns/1ps

module leaf_user_kernel #(
    parameter int NUM_PORTS = 4
) (
    input  logic                                        clk_user,
    input  logic                                        reset,
    input  logic [NUM_PORTS*leaf_pkg::payload_bits-1:0] dout_leaf_interface2user,
    input  logic [NUM_PORTS-1:0]                        vld_interface2user,
    output logic [NUM_PORTS-1:0]                        ack_user2interface,
    output logic [NUM_PORTS*leaf_pkg::payload_bits-1:0] din_leaf_user2interface,
    output logic [NUM_PORTS-1:0]                        vld_user2interface,
    input  logic [NUM_PORTS-1:0]                        ack_interface2user
);

    import leaf_pkg::*;

    logic run_q;

    // ack stays low through reset and its first cycle out
    always_ff @(posedge clk_user) begin
        if (reset) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        logic [payload_bits-1:0] word_q;
        logic                    word_vld_q;
        logic [payload_bits-1:0] sum_q;
        logic                    pend_q;
        logic                    accept;
        logic                    move;
        logic                    take;

        assign take   = pend_q && ack_interface2user[p];
        assign move   = word_vld_q && (!pend_q || take);   // new sum replaces the old one
        assign accept = vld_interface2user[p] && ack_user2interface[p];

        assign ack_user2interface[p] = run_q && (!word_vld_q || move);

        always_ff @(posedge clk_user) begin
            if (accept) begin
                word_q <= dout_leaf_interface2user[p*payload_bits +: payload_bits];
            end
        end

        always_ff @(posedge clk_user) begin
            if (reset) begin
                word_vld_q <= 1'b0;
                sum_q      <= '0;
                pend_q     <= 1'b0;
            end else begin
                if (accept) begin
                    word_vld_q <= 1'b1;
                end else if (move) begin
                    word_vld_q <= 1'b0;
                end
                if (move) begin
                    sum_q  <= sum_q + word_q;   // wraps mod 2^32
                    pend_q <= 1'b1;
                end else if (take) begin
                    pend_q <= 1'b0;
                end
            end
        end

        assign din_leaf_user2interface[p*payload_bits +: payload_bits] = sum_q;
        assign vld_user2interface[p] = pend_q;
    end

endmodule

// File: hw/leaf_i4o4.sv
`timescale 1ns/1ps

module leaf_i4o4 #(
    parameter int LEAF_ID    = 3,
    parameter int DEST_LEAF  = 9,
    parameter int NUM_PORTS  = 4,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                             clk_400,
    input  logic                             reset,
    input  logic [leaf_pkg::packet_bits-1:0] din_leaf_bft2interface,
    output logic [leaf_pkg::packet_bits-1:0] dout_leaf_interface2bft,
    input  logic                             resend,
    input  logic                             ap_start
);

    import leaf_pkg::*;

    logic [NUM_PORTS*payload_bits-1:0] dout_leaf_interface2user;
    logic [NUM_PORTS-1:0]              vld_interface2user;
    logic [NUM_PORTS-1:0]              ack_user2interface;
    logic [NUM_PORTS*payload_bits-1:0] din_leaf_user2interface;
    logic [NUM_PORTS-1:0]              vld_user2interface;
    logic [NUM_PORTS-1:0]              ack_interface2user;
    logic                              reset_ap_start_user;

    leaf_interface #(
        .LEAF_ID    (LEAF_ID),
        .DEST_LEAF  (DEST_LEAF),
        .NUM_PORTS  (NUM_PORTS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) leaf_interface_inst (
        .clk_400                  (clk_400),
        .reset                    (reset),
        .din_leaf_bft2interface   (din_leaf_bft2interface),
        .dout_leaf_interface2bft  (dout_leaf_interface2bft),
        .resend                   (resend),
        .ap_start                 (ap_start),
        .reset_ap_start_user      (reset_ap_start_user),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user),
        .ack_user2interface       (ack_user2interface),
        .din_leaf_user2interface  (din_leaf_user2interface),
        .vld_user2interface       (vld_user2interface),
        .ack_interface2user       (ack_interface2user)
    );

    leaf_user_kernel #(
        .NUM_PORTS (NUM_PORTS)
    ) leaf_user_kernel_inst (
        .clk_user                 (clk_400),   // single clock leaf
        .reset                    (reset_ap_start_user),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user),
        .ack_user2interface       (ack_user2interface),
        .din_leaf_user2interface  (din_leaf_user2interface),
        .vld_user2interface       (vld_user2interface),
        .ack_interface2user       (ack_interface2user)
    );

endmodule

// File: verif/leaf_i4o4_tb.sv
`timescale 1ns/1ps

module leaf_i4o4_tb;

    import leaf_pkg::*;

    localparam int leaf_id         = 3;
    localparam int dest_leaf       = 9;
    localparam int num_ports       = 4;
    localparam int fifo_depth      = 16;
    localparam int total_packets   = 32 + 32 + 32 + 40 + 64;   // sum over the five tests
    localparam int watchdog_cycles = 20 * total_packets + 2000;
    localparam int drain_limit     = 1000;

    logic                    clk_400;
    logic                    reset;
    logic                    resend;
    logic                    ap_start;
    logic [packet_bits-1:0]  din_leaf_bft2interface;
    logic [packet_bits-1:0]  dout_leaf_interface2bft;
    logic                    started;
    logic [payload_bits-1:0] model_sum [num_ports];
    logic [payload_bits-1:0] exp_q [num_ports][$];   // expected sums per port, in order
    logic [addr_bits-1:0]    exp_seq [num_ports] = '{default: '0};
    int                      wait_cnt [num_ports] = '{default: 0};
    int                      errors = 0;
    int                      timeouts = 0;
    int                      sent = 0;
    int                      checked = 0;

    leaf_i4o4 #(
        .LEAF_ID    (leaf_id),
        .DEST_LEAF  (dest_leaf),
        .NUM_PORTS  (num_ports),
        .FIFO_DEPTH (fifo_depth)
    ) leaf_i4o4_inst (
        .clk_400                 (clk_400),
        .reset                   (reset),
        .din_leaf_bft2interface  (din_leaf_bft2interface),
        .dout_leaf_interface2bft (dout_leaf_interface2bft),
        .resend                  (resend),
        .ap_start                (ap_start)
    );

    initial begin
        clk_400 = 1'b0;
        forever #4 clk_400 = ~clk_400;
    end

    // output rules that hold on every cycle
    assert property (@(negedge clk_400) resend |-> dout_leaf_interface2bft == '0)
        else begin
            errors = errors + 1;
            $display("mismatch dout_leaf_interface2bft during resend: got 0x%h expected 0x%h",
                     dout_leaf_interface2bft, {packet_bits{1'b0}});
        end

    assert property (@(negedge clk_400) (reset || !started) |-> !dout_leaf_interface2bft[48])
        else begin
            errors = errors + 1;
            $display("output packet marked valid before ap_start");
        end

    assert property (@(negedge clk_400) dout_leaf_interface2bft[48] |->
                     (dout_leaf_interface2bft[47:43] == leaf_bits'(dest_leaf) &&
                      int'(dout_leaf_interface2bft[42:39]) < num_ports))
        else begin
            errors = errors + 1;
            $display("mismatch dout_leaf_interface2bft header: got leaf 0x%h port 0x%h",
                     dout_leaf_interface2bft[47:43], dout_leaf_interface2bft[42:39]);
        end

    task automatic check_result(input logic [packet_bits-1:0] pkt);
        int                      p;
        logic [payload_bits-1:0] exp_sum;
        p = int'(pkt[42:39]);
        if (p < num_ports) begin   // header assertion covers the rest
            assert (exp_q[p].size() > 0) else begin
                errors = errors + 1;
                $display("port %0d produced a result that no input asked for", p);
            end
            if (exp_q[p].size() > 0) begin
                exp_sum = exp_q[p].pop_front();
                assert (pkt[38:32] == exp_seq[p]) else begin
                    errors = errors + 1;
                    $display("mismatch seq port %0d: got 0x%h expected 0x%h",
                             p, pkt[38:32], exp_seq[p]);
                end
                assert (pkt[31:0] == exp_sum) else begin
                    errors = errors + 1;
                    $display("mismatch payload port %0d: got 0x%h expected 0x%h",
                             p, pkt[31:0], exp_sum);
                end
                exp_seq[p] = exp_seq[p] + 7'd1;   // wraps at 128
                checked = checked + 1;
            end
        end
    endtask

    always @(negedge clk_400) begin
        if (!reset && dout_leaf_interface2bft[48]) begin
            check_result(dout_leaf_interface2bft);
        end
    end

    // round robin fairness, seen at the output fifo read side
    always @(negedge clk_400) begin
        logic [num_ports-1:0] fifo_vld;
        logic [num_ports-1:0] fifo_ack;
        fifo_vld = leaf_i4o4_inst.leaf_interface_inst.out_vld;
        fifo_ack = leaf_i4o4_inst.leaf_interface_inst.out_ack;
        if (!reset) begin
            for (int p = 0; p < num_ports; p++) begin
                if (fifo_ack[p] || !fifo_vld[p]) begin
                    wait_cnt[p] = 0;
                end else if (|fifo_ack) begin
                    wait_cnt[p] = wait_cnt[p] + 1;
                    assert (wait_cnt[p] <= num_ports) else begin
                        errors = errors + 1;
                        $display("port %0d passed over %0d times while holding data",
                                 p, wait_cnt[p]);
                    end
                end
            end
        end
    end

    function automatic int total_errors();
        return errors + timeouts;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int p = 0; p < num_ports; p++) begin
            n = n + exp_q[p].size();
        end
        return n;
    endfunction

    // holds the packet on the bus from this edge to the next
    task automatic send_packet(input logic valid, input logic [leaf_bits-1:0] leaf,
                               input logic [port_bits-1:0] port,
                               input logic [payload_bits-1:0] payload);
        int p;
        p = int'(port);
        @(posedge clk_400);
        din_leaf_bft2interface <= {valid, leaf, port, addr_bits'($urandom), payload};
        if (valid && leaf == leaf_bits'(leaf_id) && p < num_ports) begin
            model_sum[p] = model_sum[p] + payload;
            exp_q[p].push_back(model_sum[p]);
        end
        sent = sent + 1;
    endtask

    task automatic release_bus();
        @(posedge clk_400);
        din_leaf_bft2interface <= '0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (pending() != 0 && n < drain_limit) begin
            @(posedge clk_400);
            n = n + 1;
        end
        if (pending() != 0) begin
            timeouts = timeouts + 1;
            $display("gave up waiting, %0d results never arrived", pending());
        end
        repeat (8) @(posedge clk_400);   // room for stray extra results
    endtask

    task automatic report_test(input string name, input int errs_before);
        int errs;
        errs = total_errors() - errs_before;
        $display("test %s: %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
    endtask

    initial begin
        int errs;
        int gap;
        void'($urandom(32'h5186_8c55));
        reset                  = 1'b1;
        resend                 = 1'b0;
        ap_start               = 1'b0;
        din_leaf_bft2interface = '0;
        started                = 1'b0;
        for (int p = 0; p < num_ports; p++) begin
            model_sum[p] = '0;
        end
        repeat (3) @(posedge clk_400);
        reset <= 1'b0;

        errs = total_errors();
        for (int i = 0; i < 32; i++) begin
            send_packet(1'b1, leaf_bits'(leaf_id), port_bits'(i % num_ports), $urandom);
        end
        release_bus();
        repeat (20) @(posedge clk_400);   // kernel still held in reset here
        @(posedge clk_400);
        ap_start <= 1'b1;
        started  <= 1'b1;
        @(posedge clk_400);
        ap_start <= 1'b0;
        wait_drain();
        report_test("start_hold", errs);

        errs = total_errors();
        for (int i = 0; i < 32; i++) begin
            send_packet(1'b1, leaf_bits'(leaf_id), port_bits'($urandom % num_ports), $urandom);
            gap = int'($urandom % 3);
            if (gap > 0) begin
                release_bus();
                repeat (gap - 1) @(posedge clk_400);
            end
        end
        release_bus();
        wait_drain();
        report_test("random_sums", errs);

        errs = total_errors();
        for (int i = 0; i < 32; i++) begin
            case (i % 4)
                0: send_packet(1'b0, leaf_bits'(leaf_id), port_bits'($urandom % num_ports),
                               $urandom);
                1: send_packet(1'b1, leaf_bits'(leaf_id + 1 + int'($urandom % 31)),
                               port_bits'($urandom % num_ports), $urandom);
                2: send_packet(1'b1, leaf_bits'(leaf_id),
                               port_bits'(num_ports + int'($urandom % (16 - num_ports))),
                               $urandom);
                default: send_packet(1'b1, leaf_bits'(leaf_id),
                                     port_bits'((i / 4) % num_ports), $urandom);
            endcase
        end
        release_bus();
        wait_drain();
        report_test("filtered_packets", errs);

        errs = total_errors();
        for (int i = 0; i < 40; i++) begin
            send_packet(1'b1, leaf_bits'(leaf_id), port_bits'(i % num_ports), $urandom);
            resend <= ($urandom % 3 == 0);
        end
        release_bus();
        resend <= 1'b0;
        wait_drain();
        report_test("resend_toggle", errs);

        errs = total_errors();
        @(posedge clk_400);
        resend <= 1'b1;   // output fifos fill up behind resend
        for (int i = 0; i < 64; i++) begin
            send_packet(1'b1, leaf_bits'(leaf_id), port_bits'(i % num_ports), $urandom);
        end
        release_bus();
        repeat (40) @(posedge clk_400);
        resend <= 1'b0;
        wait_drain();
        report_test("all_ports_loaded", errs);

        $display("%0d packets sent, %0d results checked, %0d errors",
                 sent, checked, total_errors());
        if (total_errors() == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk_400);
        $display("watchdog expired after %0d cycles", watchdog_cycles);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: build.f
hw/leaf_pkg.sv
hw/leaf_depacketizer.sv
hw/leaf_port_fifo.sv
hw/leaf_packetizer.sv
hw/leaf_interface.sv
hw/leaf_user_kernel.sv
hw/leaf_i4o4.sv
verif/leaf_i4o4_tb.sv

// File: Makefile
# Verilator build and run for the leaf testbench

VERILATOR ?= verilator
TOP       ?= leaf_i4o4_tb
RTL_TOP   ?= leaf_i4o4
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= === PASS ===

SOURCES   := $(shell cat $(FILELIST))
RTL_FILES := $(filter hw/%,$(SOURCES))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(RTL_FILES) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
